// ==== timer_pkg.sv ====
// --------------------------------------------------
// widths and register map of the timer peripheral
// offsets missing from the enums read back as zero
// --------------------------------------------------
`default_nettype none

package timer_pkg;

	// --------------------------------------------------
	// bus geometry
	// --------------------------------------------------
	// bit 3 picks the block, bits 2..0 the register
	localparam int ADR_WIDTH = 4;
	localparam int DAT_WIDTH = 32;
	localparam int SEL_WIDTH = DAT_WIDTH / 8;

	// counter, monitor and compare value
	localparam int CNT_WIDTH = 64;

	// meaning of address bit 3
	typedef enum logic [0:0] {
		BLK_COUNTER = 1'b0,
		BLK_ALARM   = 1'b1
	} blk_e;

	// --------------------------------------------------
	// register offsets
	// --------------------------------------------------
	typedef enum logic [2:0] {
		CNT_CTRL  = 3'd0,
		CNT_MON_H = 3'd2,
		CNT_MON_L = 3'd3,
		CNT_VAL_H = 3'd6,
		CNT_VAL_L = 3'd7
	} cnt_reg_e;

	typedef enum logic [2:0] {
		ALM_CTRL   = 3'd0,
		ALM_STATUS = 3'd1,
		ALM_CMP_H  = 3'd2,
		ALM_CMP_L  = 3'd3
	} alm_reg_e;

	// command bits in CNT_CTRL, both self-clearing
	localparam int COPY_BIT  = 0;
	localparam int CLEAR_BIT = 7;

	// ALM_CTRL bits, writing a one to ACK_BIT drops pending
	localparam int ENABLE_BIT = 0;
	localparam int ACK_BIT    = 7;

endpackage

`default_nettype wire

// ==== timer_bus_decoder.sv ====
// --------------------------------------------------
// splits the bus between counter and alarm blocks
// ack is combinational, no wait states or errors
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module timer_bus_decoder (
	input  wire  [timer_pkg::ADR_WIDTH-1:0]      wb_adr_i,
	input  wire                                  wb_stb_i,
	input  wire  [timer_pkg::DAT_WIDTH-1:0]      cnt_rdata_i,
	input  wire  [timer_pkg::DAT_WIDTH-1:0]      alm_rdata_i,
	output logic [timer_pkg::ADR_WIDTH-2:0]      reg_adr_o,
	output logic                                 cnt_stb_o,
	output logic                                 alm_stb_o,
	output logic [timer_pkg::DAT_WIDTH-1:0]      wb_dat_o,
	output logic                                 wb_ack_o
);

	timer_pkg::blk_e blk;

	// top address bit picks the block
	assign blk       = timer_pkg::blk_e'(wb_adr_i[timer_pkg::ADR_WIDTH-1]);
	assign reg_adr_o = wb_adr_i[timer_pkg::ADR_WIDTH-2:0];

	// strobe reaches one block only
	assign cnt_stb_o = wb_stb_i && (blk == timer_pkg::BLK_COUNTER);
	assign alm_stb_o = wb_stb_i && (blk == timer_pkg::BLK_ALARM);

	// read data return
	always_comb begin
		case (blk)
			timer_pkg::BLK_COUNTER: wb_dat_o = cnt_rdata_i;
			timer_pkg::BLK_ALARM:   wb_dat_o = alm_rdata_i;
			default:                wb_dat_o = '0;
		endcase
	end

	// always ready
	assign wb_ack_o = wb_stb_i;

endmodule

`default_nettype wire

// ==== clock_counter.sv ====
// --------------------------------------------------
// free-running 64-bit counter with snapshot monitor
// commands act one edge after the CNT_CTRL write
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module clock_counter (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire  [timer_pkg::ADR_WIDTH-2:0]      reg_adr_i,
	input  wire  [timer_pkg::DAT_WIDTH-1:0]      wb_dat_i,
	input  wire                                  wb_we_i,
	input  wire  [timer_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                  stb_i,
	output logic [timer_pkg::DAT_WIDTH-1:0]      rdata_o,
	output logic [timer_pkg::CNT_WIDTH-1:0]      counter_o
);

	logic                             copy_q;
	logic                             clear_q;
	logic [timer_pkg::CNT_WIDTH-1:0]  counter_q;
	logic [timer_pkg::CNT_WIDTH-1:0]  monitor_q;
	logic                             ctrl_wr;

	// commands only through byte lane 0
	assign ctrl_wr = stb_i && wb_we_i && wb_sel_i[0]
		&& (reg_adr_i == timer_pkg::CNT_CTRL);

	// --------------------------------------------------
	// command flags, counter and monitor
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			copy_q    <= 1'b0;
			clear_q   <= 1'b0;
			counter_q <= '0;
			monitor_q <= '0;
		end else begin
			if (ctrl_wr) begin
				copy_q  <= wb_dat_i[timer_pkg::COPY_BIT];
				clear_q <= wb_dat_i[timer_pkg::CLEAR_BIT];
			end else begin
				// flags last a single cycle
				copy_q  <= 1'b0;
				clear_q <= 1'b0;
			end

			if (clear_q) begin
				counter_q <= '0;
			end else begin
				counter_q <= counter_q + 1'b1;
			end

			// snapshot of the count seen in the flag cycle
			if (copy_q) begin
				monitor_q <= counter_q;
			end
		end
	end

	// --------------------------------------------------
	// register readback
	// --------------------------------------------------
	always_comb begin
		rdata_o = '0;
		case (timer_pkg::cnt_reg_e'(reg_adr_i))
			timer_pkg::CNT_CTRL: begin
				rdata_o[timer_pkg::COPY_BIT]  = copy_q;
				rdata_o[timer_pkg::CLEAR_BIT] = clear_q;
			end
			timer_pkg::CNT_MON_H: rdata_o = monitor_q[timer_pkg::CNT_WIDTH-1:timer_pkg::DAT_WIDTH];
			timer_pkg::CNT_MON_L: rdata_o = monitor_q[timer_pkg::DAT_WIDTH-1:0];
			timer_pkg::CNT_VAL_H: rdata_o = counter_q[timer_pkg::CNT_WIDTH-1:timer_pkg::DAT_WIDTH];
			timer_pkg::CNT_VAL_L: rdata_o = counter_q[timer_pkg::DAT_WIDTH-1:0];
			default:              rdata_o = '0;
		endcase
	end

	assign counter_o = counter_q;

endmodule

`default_nettype wire

// ==== alarm_unit.sv ====
// --------------------------------------------------
// single alarm channel with sticky pending flag
// irq_o follows pending AND enable, registered
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module alarm_unit (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire  [timer_pkg::ADR_WIDTH-2:0]      reg_adr_i,
	input  wire  [timer_pkg::DAT_WIDTH-1:0]      wb_dat_i,
	input  wire                                  wb_we_i,
	input  wire  [timer_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                  stb_i,
	input  wire  [timer_pkg::CNT_WIDTH-1:0]      counter_i,
	output logic [timer_pkg::DAT_WIDTH-1:0]      rdata_o,
	output logic                                 irq_o
);

	logic [timer_pkg::CNT_WIDTH-1:0]  compare_q;
	logic                             enable_q;
	logic                             pending_q;
	logic                             irq_q;
	logic                             enable_next;
	logic                             pending_next;
	logic                             ctrl_wr;
	logic                             cmp_h_wr;
	logic                             cmp_l_wr;
	logic                             write;

	assign write    = stb_i && wb_we_i;
	assign ctrl_wr  = write && wb_sel_i[0] && (reg_adr_i == timer_pkg::ALM_CTRL);
	assign cmp_h_wr = write && (reg_adr_i == timer_pkg::ALM_CMP_H);
	assign cmp_l_wr = write && (reg_adr_i == timer_pkg::ALM_CMP_L);

	// --------------------------------------------------
	// next enable and pending
	// --------------------------------------------------
	always_comb begin
		enable_next  = enable_q;
		pending_next = pending_q;
		if (ctrl_wr) begin
			enable_next = wb_dat_i[timer_pkg::ENABLE_BIT];
		end
		if (enable_q && (counter_i >= compare_q)) begin
			pending_next = 1'b1;
		end
		// acknowledge wins over a match in the same cycle
		if (ctrl_wr && wb_dat_i[timer_pkg::ACK_BIT]) begin
			pending_next = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			enable_q  <= 1'b0;
			pending_q <= 1'b0;
			irq_q     <= 1'b0;
			compare_q <= '0;
		end else begin
			enable_q  <= enable_next;
			pending_q <= pending_next;
			// built from next values so irq never outlives enable
			irq_q     <= pending_next && enable_next;
			for (int i = 0; i < timer_pkg::SEL_WIDTH; i++) begin
				if (cmp_h_wr && wb_sel_i[i]) begin
					compare_q[timer_pkg::DAT_WIDTH + 8*i +: 8] <= wb_dat_i[8*i +: 8];
				end
				if (cmp_l_wr && wb_sel_i[i]) begin
					compare_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
				end
			end
		end
	end

	// --------------------------------------------------
	// register readback
	// --------------------------------------------------
	always_comb begin
		rdata_o = '0;
		case (timer_pkg::alm_reg_e'(reg_adr_i))
			timer_pkg::ALM_CTRL:   rdata_o[timer_pkg::ENABLE_BIT] = enable_q;
			timer_pkg::ALM_STATUS: rdata_o[0] = pending_q;
			timer_pkg::ALM_CMP_H:  rdata_o = compare_q[timer_pkg::CNT_WIDTH-1:timer_pkg::DAT_WIDTH];
			timer_pkg::ALM_CMP_L:  rdata_o = compare_q[timer_pkg::DAT_WIDTH-1:0];
			default:               rdata_o = '0;
		endcase
	end

	assign irq_o = irq_q;

endmodule

`default_nettype wire

// ==== timer_subsystem.sv ====
// --------------------------------------------------
// timer peripheral top, one slave port and one irq
// single alarm channel, no prescaler
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module timer_subsystem (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire  [timer_pkg::ADR_WIDTH-1:0]      wb_adr_i,
	input  wire  [timer_pkg::DAT_WIDTH-1:0]      wb_dat_i,
	input  wire                                  wb_we_i,
	input  wire  [timer_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                  wb_stb_i,
	output logic [timer_pkg::DAT_WIDTH-1:0]      wb_dat_o,
	output logic                                 wb_ack_o,
	output logic                                 irq_o
);

	logic [timer_pkg::ADR_WIDTH-2:0]  reg_adr;
	logic                             cnt_stb;
	logic                             alm_stb;
	logic [timer_pkg::DAT_WIDTH-1:0]  cnt_rdata;
	logic [timer_pkg::DAT_WIDTH-1:0]  alm_rdata;
	// live count feeding the alarm compare
	logic [timer_pkg::CNT_WIDTH-1:0]  counter_value;

	timer_bus_decoder decoder_i (
		.wb_adr_i    (wb_adr_i),
		.wb_stb_i    (wb_stb_i),
		.cnt_rdata_i (cnt_rdata),
		.alm_rdata_i (alm_rdata),
		.reg_adr_o   (reg_adr),
		.cnt_stb_o   (cnt_stb),
		.alm_stb_o   (alm_stb),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o)
	);

	clock_counter counter_i (
		.clk       (clk),
		.reset     (reset),
		.reg_adr_i (reg_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_sel_i  (wb_sel_i),
		.stb_i     (cnt_stb),
		.rdata_o   (cnt_rdata),
		.counter_o (counter_value)
	);

	alarm_unit alarm_i (
		.clk       (clk),
		.reset     (reset),
		.reg_adr_i (reg_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_sel_i  (wb_sel_i),
		.stb_i     (alm_stb),
		.counter_i (counter_value),
		.rdata_o   (alm_rdata),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

// ==== timer_assertions.sv ====
// --------------------------------------------------
// bound to timer_subsystem, enable taken from alarm_i
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module timer_assertions (
	input wire clk,
	input wire reset,
	input wire wb_stb_i,
	input wire wb_ack_o,
	input wire irq_o,
	input wire enable_i
);

	// number of failed checks so far
	int fail_count = 0;

	// bus is always ready
	ack_follows_stb: assert property (@(posedge clk) wb_ack_o == wb_stb_i)
		else begin
			fail_count++;
			$error("ack differs from stb");
		end

	// an edge taken in reset leaves irq low
	irq_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !irq_o)
		else begin
			fail_count++;
			$error("irq high after a reset edge");
		end

	irq_needs_enable: assert property (@(posedge clk) disable iff (reset) !enable_i |-> !irq_o)
		else begin
			fail_count++;
			$error("irq high with alarm disabled");
		end

endmodule

`default_nettype wire

// ==== timer_tb.sv ====
// --------------------------------------------------
// table driven test of the timer over the slave port
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module timer_tb;

	typedef enum logic [2:0] {OP_WRITE, OP_RD_EQ, OP_RD_LT, OP_RD_GE, OP_WAIT_IRQ, OP_IDLE} op_e;

	// rel compares against the last saved read plus exp
	typedef struct {
		op_e                             op;
		logic [timer_pkg::ADR_WIDTH-1:0] adr;
		logic [timer_pkg::DAT_WIDTH-1:0] dat;
		logic [timer_pkg::SEL_WIDTH-1:0] sel;
		logic [timer_pkg::DAT_WIDTH-1:0] exp;
		bit                              save;
		bit                              rel;
	} step_t;

	logic                            clk;
	logic                            reset;
	logic [timer_pkg::ADR_WIDTH-1:0] wb_adr_i;
	logic [timer_pkg::DAT_WIDTH-1:0] wb_dat_i;
	logic                            wb_we_i;
	logic [timer_pkg::SEL_WIDTH-1:0] wb_sel_i;
	logic                            wb_stb_i;
	logic [timer_pkg::DAT_WIDTH-1:0] wb_dat_o;
	logic                            wb_ack_o;
	logic                            irq_o;

	step_t                           steps[$];
	logic [timer_pkg::DAT_WIDTH-1:0] ref_val;
	logic [timer_pkg::DAT_WIDTH-1:0] rand_val;
	int                              seed = 66;
	int                              cycle_count = 0;
	int                              cycle_limit = 200;
	bit                              failed = 1'b0;
	bit                              passed = 1'b0;

	timer_subsystem dut_i (
		.clk(clk), .reset(reset), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i), .wb_sel_i(wb_sel_i), .wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .irq_o(irq_o)
	);

	bind timer_subsystem timer_assertions assertions_i (
		.clk(clk), .reset(reset), .wb_stb_i(wb_stb_i), .wb_ack_o(wb_ack_o),
		.irq_o(irq_o), .enable_i(alarm_i.enable_q)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_failure;
		failed = 1'b1;
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: test did not finish within %0d cycles", cycle_limit);
			stop_on_failure();
		end
	end

	// first failed bound assertion ends the run
	always @(dut_i.assertions_i.fail_count) begin
		if (dut_i.assertions_i.fail_count != 0) begin
			$display("A bound assertion failed at time %0t ns", $time);
			stop_on_failure();
		end
	end

	// ----------------------------------------------
	// table helpers
	// ----------------------------------------------
	function automatic void add_step(op_e op, logic [3:0] adr, logic [31:0] dat,
			logic [3:0] sel, logic [31:0] exp, bit save, bit rel);
		step_t s;
		s.op = op;
		s.adr = adr;
		s.dat = dat;
		s.sel = sel;
		s.exp = exp;
		s.save = save;
		s.rel = rel;
		steps.push_back(s);
	endfunction

	function automatic logic [3:0] cnt_adr(timer_pkg::cnt_reg_e r);
		return {timer_pkg::BLK_COUNTER, r};
	endfunction

	function automatic logic [3:0] alm_adr(timer_pkg::alm_reg_e r);
		return {timer_pkg::BLK_ALARM, r};
	endfunction

	// byte lane write rule of the compare registers
	function automatic logic [31:0] merge_bytes(logic [31:0] old_v, logic [31:0] new_v,
			logic [3:0] sel);
		logic [31:0] res;
		res = old_v;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
		end
		return res;
	endfunction

	// ----------------------------------------------
	// compare tasks
	// ----------------------------------------------
	task automatic check_data(input op_e op, input logic [timer_pkg::DAT_WIDTH-1:0] exp,
			input logic [timer_pkg::DAT_WIDTH-1:0] act);
		bit    ok;
		string rel_txt;
		ok = (op == OP_RD_EQ) ? (act == exp) : (op == OP_RD_LT) ? (act < exp) : (act >= exp);
		rel_txt = (op == OP_RD_EQ) ? "==" : (op == OP_RD_LT) ? "<" : ">=";
		if (!ok) begin
			$display("Error: time %0t ns, wb_dat_o expected %s 0x%08h, actual 0x%08h",
				$time, rel_txt, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_irq(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: time %0t ns, irq_o expected %b, actual %b", $time, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic apply_step(input step_t s);
		logic [timer_pkg::DAT_WIDTH-1:0] exp_v;
		int                              n;
		@(negedge clk);
		wb_adr_i = s.adr;
		wb_dat_i = s.dat;
		wb_sel_i = s.sel;
		wb_we_i  = (s.op == OP_WRITE);
		wb_stb_i = (s.op == OP_WRITE) || (s.op == OP_RD_EQ) || (s.op == OP_RD_LT)
			|| (s.op == OP_RD_GE);
		exp_v = s.rel ? ref_val + s.exp : s.exp;
		case (s.op)
			OP_RD_EQ, OP_RD_LT, OP_RD_GE: begin
				#1;
				check_data(s.op, exp_v, wb_dat_o);
				if (s.save) ref_val = wb_dat_o;
			end
			OP_WAIT_IRQ: begin
				n = 0;
				while (n < int'(s.dat) && irq_o !== s.exp[0]) begin
					@(negedge clk);
					n++;
				end
				check_irq(s.exp[0], irq_o);
			end
			OP_IDLE: repeat (s.dat) @(negedge clk);
			default: ;
		endcase
	endtask

	initial begin
		reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_sel_i = '0;
		wb_stb_i = 1'b0;
		ref_val = '0;
		rand_val = $random(seed);

		// after reset, all but the live low count read zero
		for (int i = 0; i < 7; i++) add_step(OP_RD_EQ, {1'b0, 3'(i)}, 0, 4'hf, 0, 0, 0);
		for (int i = 0; i < 8; i++) add_step(OP_RD_EQ, {1'b1, 3'(i)}, 0, 4'hf, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 1, 0, 0, 0, 0);
		// counting, then clear
		add_step(OP_RD_GE, cnt_adr(timer_pkg::CNT_VAL_L), 0, 4'hf, 1, 1, 0);
		add_step(OP_IDLE, 0, 4, 0, 0, 0, 0);
		add_step(OP_RD_GE, cnt_adr(timer_pkg::CNT_VAL_L), 0, 4'hf, 1, 0, 1);
		add_step(OP_WRITE, cnt_adr(timer_pkg::CNT_CTRL), 32'h80, 4'h1, 0, 0, 0);
		add_step(OP_RD_EQ, cnt_adr(timer_pkg::CNT_CTRL), 0, 4'hf, 32'h80, 0, 0);
		add_step(OP_RD_LT, cnt_adr(timer_pkg::CNT_VAL_L), 0, 4'hf, 8, 0, 0);
		add_step(OP_RD_EQ, cnt_adr(timer_pkg::CNT_VAL_H), 0, 4'hf, 0, 0, 0);
		// snapshot
		add_step(OP_WRITE, cnt_adr(timer_pkg::CNT_CTRL), 32'h01, 4'h1, 0, 0, 0);
		add_step(OP_RD_EQ, cnt_adr(timer_pkg::CNT_CTRL), 0, 4'hf, 32'h01, 0, 0);
		add_step(OP_RD_GE, cnt_adr(timer_pkg::CNT_MON_L), 0, 4'hf, 1, 1, 0);
		add_step(OP_IDLE, 0, 20, 0, 0, 0, 0);
		add_step(OP_RD_EQ, cnt_adr(timer_pkg::CNT_MON_H), 0, 4'hf, 0, 0, 0);
		add_step(OP_RD_EQ, cnt_adr(timer_pkg::CNT_MON_L), 0, 4'hf, 0, 0, 1);
		add_step(OP_RD_GE, cnt_adr(timer_pkg::CNT_VAL_L), 0, 4'hf, 0, 0, 1);
		// compare readback, full and partial lanes
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_L), rand_val, 4'hf, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_CMP_L), 0, 4'hf, rand_val, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_H), 32'h1234_5678, 4'hf, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_H), 32'haabb_ccdd, 4'h5, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_CMP_H), 0, 4'hf,
			merge_bytes(32'h1234_5678, 32'haabb_ccdd, 4'h5), 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_L), 32'hffff_ffff, 4'h2, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_CMP_L), 0, 4'hf,
			merge_bytes(rand_val, 32'hffff_ffff, 4'h2), 0, 0);
		// alarm a little ahead of a cleared counter
		add_step(OP_WRITE, cnt_adr(timer_pkg::CNT_CTRL), 32'h80, 4'h1, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_H), 0, 4'hf, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_L), 40, 4'hf, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CTRL), 32'h01, 4'h1, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_STATUS), 0, 4'hf, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 100, 0, 1, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_STATUS), 0, 4'hf, 1, 0, 0);
		// acknowledge with the compare far ahead
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_H), 32'hffff_ffff, 4'hf, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CTRL), 32'h81, 4'h1, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_STATUS), 0, 4'hf, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 1, 0, 0, 0, 0);
		// disabled alarm with a passed compare value
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CTRL), 0, 4'h1, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_H), 0, 4'hf, 0, 0, 0);
		add_step(OP_WRITE, alm_adr(timer_pkg::ALM_CMP_L), 0, 4'hf, 0, 0, 0);
		add_step(OP_IDLE, 0, 10, 0, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 1, 0, 0, 0, 0);
		add_step(OP_RD_EQ, alm_adr(timer_pkg::ALM_STATUS), 0, 4'hf, 0, 0, 0);
		cycle_limit = steps.size() * 64 + 200;

		repeat (4) @(negedge clk);
		reset = 1'b0;
		foreach (steps[i]) apply_step(steps[i]);

		@(negedge clk);
		passed = 1'b1;
		$display("STATUS: PASS");
		$finish;
	end

	// a failed assertion can end the run here
	final begin
		if (!passed && !failed) $display("STATUS: FAIL");
	end

endmodule

`default_nettype wire

// ==== list.f ====
timer_pkg.sv
timer_bus_decoder.sv
clock_counter.sv
alarm_unit.sv
timer_subsystem.sv
timer_assertions.sv
timer_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = timer_tb
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
